// File: logic/video_pkg.sv
// ==============================
// Video package
// Screen geometry, memory sizes and the pixel pipeline depth
// ==============================

package video_pkg;

    // Horizontal geometry in pixel strobes
    localparam int H_TOTAL  = 384;
    localparam int H_ACTIVE = 256;        // Visible from h = 0
    localparam int HS_START = 296;
    localparam int HS_LEN   = 32;

    // Vertical geometry in lines
    localparam int V_TOTAL  = 262;
    localparam int V_START  = 16;         // First visible line
    localparam int V_END    = 240;        // First line past the visible range
    localparam int VS_START = 248;
    localparam int VS_LEN   = 3;

    localparam int H_W = $clog2(H_TOTAL); // Counter widths
    localparam int V_W = $clog2(V_TOTAL);

    // Strobes from timer position to colour output
    localparam int PIX_DELAY = 2;

    // CPU side of the tile RAM with bit 10 as the bank select
    localparam int CHRAM_AW = 11;
    localparam int TILE_AW  = CHRAM_AW - 1;

    localparam int CHROM_AW = 11;         // Tile code and tile row
    localparam int PAL_AW   = 6;          // Attribute colour and pixel bits
    localparam int COLOR_W  = 4;

endpackage

// File: logic/video_if.sv
// ==============================
// Video interfaces
// Timing bundle from the timer and the CPU tile RAM bus
// ==============================

`timescale 1ns/1ps

interface video_timing_if import video_pkg::*; ();
    logic [H_W-1:0] h;
    logic [V_W-1:0] v;
    logic           pix_cen;  // Pixel strobe
    logic           lhbl;     // Active-high line visible
    logic           lvbl;     // Active-high frame visible
    logic           hs;
    logic           vs;

    modport source (output h, v, pix_cen, lhbl, lvbl, hs, vs);
    modport sink   (input  h, v, pix_cen, lhbl, lvbl, hs, vs);
endinterface

interface cpu_bus_if import video_pkg::*; ();
    logic [CHRAM_AW-1:0] addr;
    logic [7:0]          dout;        // Write data from the CPU
    logic                char_cs;
    logic                rnw;
    logic [7:0]          chram_dout;  // Read data back to the CPU

    // Request side on the initiator, read data back from the target
    modport initiator (
        output addr, dout, char_cs, rnw,
        input  chram_dout
    );
    modport target (
        input  addr, dout, char_cs, rnw,
        output chram_dout
    );
endinterface

// File: logic/video_timer.sv
// ==============================
// Video timer
// Line and frame counters with blanking and sync decode
// ==============================

`timescale 1ns/1ps

module video_timer import video_pkg::*; (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           pix_cen,
    video_timing_if.source vt
);

    logic [H_W-1:0] h;
    logic [V_W-1:0] v;
    logic           line_end;
    logic           frame_end;

    assign line_end  = h == H_W'(H_TOTAL - 1);
    assign frame_end = v == V_W'(V_TOTAL - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            h <= '0;
            v <= '0;
        end else if (pix_cen) begin
            if (line_end) begin
                h <= '0;
                v <= frame_end ? '0 : v + 1'b1; // Next line on the wrap
            end else begin
                h <= h + 1'b1;
            end
        end
    end

    assign vt.h       = h;
    assign vt.v       = v;
    assign vt.pix_cen = pix_cen;

    // Decode straight from the counters so every flag lines up with h and v
    assign vt.lhbl = h < H_W'(H_ACTIVE);
    assign vt.lvbl = (v >= V_W'(V_START)) && (v < V_W'(V_END));
    assign vt.hs   = (h >= H_W'(HS_START)) && (h < H_W'(HS_START + HS_LEN));
    assign vt.vs   = (v >= V_W'(VS_START)) && (v < V_W'(VS_START + VS_LEN));

    // Both counters wrap before their totals
    a_counter_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        (h < H_W'(H_TOTAL)) && (v < V_W'(V_TOTAL))
    ) else $error("video_timer counter out of range h=%0d v=%0d", h, v);

endmodule

// File: logic/char_layer.sv
// ==============================
// Character layer
// Tile RAM, graphics ROM fetch and a 2 bpp pixel shifter
// ==============================

`timescale 1ns/1ps

module char_layer import video_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    video_timing_if.sink        vt,
    cpu_bus_if.target           cpu,
    output logic [CHROM_AW-1:0] char_addr,
    input  logic [15:0]         char_data,
    output logic [PAL_AW-1:0]   pal_idx
);

    logic [7:0]         code_ram [2**TILE_AW];
    logic [7:0]         attr_ram [2**TILE_AW];

    logic               cpu_bank;
    logic [TILE_AW-1:0] cpu_idx;

    logic [H_W-1:0]     h_ahead;
    logic               col_wrap;
    logic [H_W-1:0]     fetch_h;
    logic [V_W-1:0]     fetch_v;
    logic [TILE_AW-1:0] vid_idx;

    logic               slot_first;
    logic               slot_second;
    logic               slot_last;

    logic [7:0]         tile_code;
    logic [3:0]         tile_col;
    logic [2:0]         tile_row;
    logic [3:0]         cur_col;  // Attribute colour of the column on screen
    logic [7:0]         sr0;      // Plane 0 shifter
    logic [7:0]         sr1;      // Plane 1 shifter

    assign cpu_bank = cpu.addr[CHRAM_AW-1];
    assign cpu_idx  = cpu.addr[TILE_AW-1:0];

    // Slot steps within each 8-pixel tile
    assign slot_first  = vt.pix_cen && (vt.h[2:0] == 3'd0);
    assign slot_second = vt.pix_cen && (vt.h[2:0] == 3'd1);
    assign slot_last   = vt.pix_cen && (vt.h[2:0] == 3'd7);

    // Fetch one column ahead; the last slot of a line fetches for the next line
    always_comb begin
        h_ahead  = vt.h + H_W'(8);
        col_wrap = h_ahead >= H_W'(H_TOTAL);
        fetch_h  = col_wrap ? h_ahead - H_W'(H_TOTAL) : h_ahead;
        if (!col_wrap)
            fetch_v = vt.v;
        else if (vt.v == V_W'(V_TOTAL - 1))
            fetch_v = '0;
        else
            fetch_v = vt.v + 1'b1;
        vid_idx = {fetch_v[7:3], fetch_h[7:3]};  // 32 x 32 tile map
    end

    // CPU port
    always_ff @(posedge clk) begin
        if (cpu.char_cs && !cpu.rnw) begin
            if (cpu_bank)
                attr_ram[cpu_idx] <= cpu.dout;
            else
                code_ram[cpu_idx] <= cpu.dout;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            cpu.chram_dout <= '0;
        else if (cpu.char_cs && cpu.rnw)
            cpu.chram_dout <= cpu_bank ? attr_ram[cpu_idx] : code_ram[cpu_idx];
    end

    // Video port, read once per slot
    always_ff @(posedge clk) begin
        if (slot_first) begin
            tile_code <= code_ram[vid_idx];
            tile_col  <= attr_ram[vid_idx][3:0];  // Low nibble picks the colour
            tile_row  <= fetch_v[2:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            char_addr <= '0;
        else if (slot_second)
            char_addr <= {tile_code, tile_row};   // Steady for the rest of the slot
    end

    // ROM data lands on the shifter as the last pixel of the old tile goes out
    always_ff @(posedge clk) begin
        if (slot_last) begin
            sr1     <= char_data[15:8];
            sr0     <= char_data[7:0];
            cur_col <= tile_col;
        end else if (vt.pix_cen) begin
            sr1 <= {sr1[6:0], 1'b0};
            sr0 <= {sr0[6:0], 1'b0};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            pal_idx <= '0;
        else if (vt.pix_cen)
            pal_idx <= {cur_col, sr1[7], sr0[7]};  // MSB is the leftmost pixel
    end

    // Selects from the top level must carry a defined RAM address
    a_cpu_addr_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        cpu.char_cs |-> !$isunknown({cpu.addr, cpu.rnw})
    );

endmodule

// File: logic/palette_mix.sv
// ==============================
// Palette mixer
// Colour PROMs, colour lookup and aligned blank/sync outputs
// ==============================

`timescale 1ns/1ps

module palette_mix import video_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    video_timing_if.sink       vt,
    input  logic [PAL_AW-1:0]  pal_idx,
    input  logic [PAL_AW-1:0]  prog_addr,
    input  logic [COLOR_W-1:0] prom_din,
    input  logic               prom_red_we,
    input  logic               prom_green_we,
    input  logic               prom_blue_we,
    output logic [COLOR_W-1:0] red,
    output logic [COLOR_W-1:0] green,
    output logic [COLOR_W-1:0] blue,
    output logic               lhbl,
    output logic               lvbl,
    output logic               hs,
    output logic               vs
);

    logic [COLOR_W-1:0] prom_r [2**PAL_AW];
    logic [COLOR_W-1:0] prom_g [2**PAL_AW];
    logic [COLOR_W-1:0] prom_b [2**PAL_AW];

    logic [COLOR_W-1:0] red_q;
    logic [COLOR_W-1:0] green_q;
    logic [COLOR_W-1:0] blue_q;
    logic [PIX_DELAY-1:0][3:0] sync_pipe;  // {lhbl, lvbl, hs, vs} per stage
    logic               visible;

    always_ff @(posedge clk) begin
        if (prom_red_we)   prom_r[prog_addr] <= prom_din;
        if (prom_green_we) prom_g[prog_addr] <= prom_din;
        if (prom_blue_we)  prom_b[prog_addr] <= prom_din;
    end

    always_ff @(posedge clk) begin
        if (vt.pix_cen) begin
            red_q   <= prom_r[pal_idx];
            green_q <= prom_g[pal_idx];
            blue_q  <= prom_b[pal_idx];
        end
    end

    // Timing flags follow the pixel through the char and colour registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            sync_pipe <= '0;
        else if (vt.pix_cen)
            sync_pipe <= {sync_pipe[PIX_DELAY-2:0], {vt.lhbl, vt.lvbl, vt.hs, vt.vs}};
    end

    assign {lhbl, lvbl, hs, vs} = sync_pipe[PIX_DELAY-1];
    assign visible = lhbl && lvbl;

    assign red   = visible ? red_q   : '0;  // Black outside the active area
    assign green = visible ? green_q : '0;
    assign blue  = visible ? blue_q  : '0;

    a_one_prom_we: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0({prom_red_we, prom_green_we, prom_blue_we})
    );

endmodule

// File: logic/arcade_video.sv
// ==============================
// Arcade video top level
// Timer, character layer and palette behind board ports
// ==============================

`timescale 1ns/1ps

module arcade_video import video_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                pix_cen,     // Pixel clock enable
    // CPU access to the tile RAM
    input  logic [CHRAM_AW-1:0] cpu_addr,
    input  logic [7:0]          cpu_dout,
    input  logic                char_cs,
    input  logic                rnw,
    output logic [7:0]          chram_dout,
    // Character graphics ROM
    output logic [CHROM_AW-1:0] char_addr,
    input  logic [15:0]         char_data,
    // Palette PROM programming
    input  logic [PAL_AW-1:0]   prog_addr,
    input  logic [COLOR_W-1:0]  prom_din,
    input  logic                prom_red_we,
    input  logic                prom_green_we,
    input  logic                prom_blue_we,
    // Video out
    output logic [COLOR_W-1:0]  red,
    output logic [COLOR_W-1:0]  green,
    output logic [COLOR_W-1:0]  blue,
    output logic                lhbl,
    output logic                lvbl,
    output logic                hs,
    output logic                vs
);

    video_timing_if    vt ();
    cpu_bus_if         cpu_bus ();
    logic [PAL_AW-1:0] pal_idx;

    assign cpu_bus.addr    = cpu_addr;
    assign cpu_bus.dout    = cpu_dout;
    assign cpu_bus.char_cs = char_cs;
    assign cpu_bus.rnw     = rnw;
    assign chram_dout      = cpu_bus.chram_dout;

    video_timer u_timer (
        .clk     ( clk     ),
        .rst_n   ( rst_n   ),
        .pix_cen ( pix_cen ),
        .vt      ( vt      )
    );

    char_layer u_char (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .vt        ( vt        ),
        .cpu       ( cpu_bus   ),
        .char_addr ( char_addr ),
        .char_data ( char_data ),
        .pal_idx   ( pal_idx   )
    );

    palette_mix u_palette (
        .clk           ( clk           ),
        .rst_n         ( rst_n         ),
        .vt            ( vt            ),
        .pal_idx       ( pal_idx       ),
        .prog_addr     ( prog_addr     ),
        .prom_din      ( prom_din      ),
        .prom_red_we   ( prom_red_we   ),
        .prom_green_we ( prom_green_we ),
        .prom_blue_we  ( prom_blue_we  ),
        .red           ( red           ),
        .green         ( green         ),
        .blue          ( blue          ),
        .lhbl          ( lhbl          ),
        .lvbl          ( lvbl          ),
        .hs            ( hs            ),
        .vs            ( vs            )
    );

endmodule

// File: sim/rom_model.svh
// ==============================
// Character ROM model
// Fixed bit mix of the ROM address
// ==============================

function automatic logic [15:0] rom_word(input logic [10:0] a);
    return (16'(a) * 16'h9E37) ^ {a[4:0], a};  // Planes 1 and 0
endfunction

// File: sim/video_checker.sv
// ==============================
// Video checker
// Screen reference model and timing assertions on the DUT ports
// ==============================

`timescale 1ns/1ps

module video_checker import video_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                pix_cen,
    input  logic [CHRAM_AW-1:0] cpu_addr,
    input  logic [7:0]          cpu_dout,
    input  logic                char_cs,
    input  logic                rnw,
    input  logic [PAL_AW-1:0]   prog_addr,
    input  logic [COLOR_W-1:0]  prom_din,
    input  logic                prom_red_we,
    input  logic                prom_green_we,
    input  logic                prom_blue_we,
    input  logic [COLOR_W-1:0]  red,
    input  logic [COLOR_W-1:0]  green,
    input  logic [COLOR_W-1:0]  blue,
    input  logic                lhbl,
    input  logic                lvbl,
    input  logic                hs,
    input  logic                vs,
    output logic                fail
);

    `include "rom_model.svh"

    logic [7:0]         code_sh [1024];
    logic [7:0]         attr_sh [1024];
    logic [COLOR_W-1:0] r_sh [64];
    logic [COLOR_W-1:0] g_sh [64];
    logic [COLOR_W-1:0] b_sh [64];

    logic       lhbl_q, lvbl_q, h_seen, v_seen;
    int         hrun, hper, hsrun, vrun, vper, vsrun;
    logic [8:0] x_cnt, y_cnt, vy;
    logic [9:0] tidx;
    logic [15:0] word;
    logic [5:0] pidx;
    logic [11:0] exp_rgb;
    logic       f_line = 1'b0, f_lper = 1'b0, f_hs = 1'b0, f_frame = 1'b0;
    logic       f_fper = 1'b0, f_vs = 1'b0, f_color = 1'b0, f_blank = 1'b0;

    assign fail = f_line | f_lper | f_hs | f_frame | f_fper | f_vs | f_color | f_blank;

    // Shadows follow the writes seen on the ports
    always_ff @(posedge clk) begin
        if (char_cs && !rnw) begin
            if (cpu_addr[10])
                attr_sh[cpu_addr[9:0]] <= cpu_dout;
            else
                code_sh[cpu_addr[9:0]] <= cpu_dout;
        end
        if (prom_red_we)   r_sh[prog_addr] <= prom_din;
        if (prom_green_we) g_sh[prog_addr] <= prom_din;
        if (prom_blue_we)  b_sh[prog_addr] <= prom_din;
    end

    // One sample per output strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            {lhbl_q, lvbl_q, h_seen, v_seen} <= '0;
            {hrun, hper, hsrun, vrun, vper, vsrun} <= '0;
            x_cnt <= '0;
            y_cnt <= '0;
        end else if (pix_cen) begin
            {lhbl_q, lvbl_q} <= {lhbl, lvbl};
            hrun  <= lhbl ? hrun + 1 : 0;
            vrun  <= lvbl ? vrun + 1 : 0;
            hsrun <= (lhbl && !lhbl_q) ? int'(hs) : hsrun + int'(hs);  // hs strobes in this line
            vsrun <= (lvbl && !lvbl_q) ? int'(vs) : vsrun + int'(vs);  // vs strobes in this frame
            hper  <= (lhbl && !lhbl_q) ? 1 : hper + 1;
            vper  <= (lvbl && !lvbl_q) ? 1 : vper + 1;
            if (lhbl && !lhbl_q) h_seen <= 1'b1;
            if (lvbl && !lvbl_q) v_seen <= 1'b1;
            x_cnt <= lhbl ? x_cnt + 1'b1 : '0;
            if (!lvbl)
                y_cnt <= '0;
            else if (lhbl_q && !lhbl)
                y_cnt <= y_cnt + 1'b1;        // Next visible line
        end
    end

    // Screen model for pixel x_cnt of line y_cnt
    always_comb begin
        vy      = y_cnt + 9'(V_START);
        tidx    = {vy[7:3], x_cnt[7:3]};
        word    = rom_word({code_sh[tidx], vy[2:0]});
        pidx    = {attr_sh[tidx][3:0], word[15 - x_cnt[2:0]], word[7 - x_cnt[2:0]]};
        exp_rgb = {r_sh[pidx], g_sh[pidx], b_sh[pidx]};
    end

    a_line_len: assert property (@(posedge clk) disable iff (!rst_n)
        pix_cen && lhbl_q && !lhbl |-> hrun == H_ACTIVE)
        else begin
            $display("FAIL %0t lhbl width exp %0d got %0d", $time, H_ACTIVE, hrun);
            f_line = 1'b1;
        end
    a_line_per: assert property (@(posedge clk) disable iff (!rst_n)
        pix_cen && lhbl && !lhbl_q && h_seen |-> hper == H_TOTAL)
        else begin
            $display("FAIL %0t lhbl period exp %0d got %0d", $time, H_TOTAL, hper);
            f_lper = 1'b1;
        end
    a_hs_len: assert property (@(posedge clk) disable iff (!rst_n)
        pix_cen && lhbl && !lhbl_q && h_seen |-> hsrun == HS_LEN)
        else begin
            $display("FAIL %0t hs strobes per line exp %0d got %0d", $time, HS_LEN, hsrun);
            f_hs = 1'b1;
        end
    a_frame_len: assert property (@(posedge clk) disable iff (!rst_n)
        pix_cen && lvbl_q && !lvbl |-> vrun == (V_END - V_START) * H_TOTAL)
        else begin
            $display("FAIL %0t lvbl width exp %0d got %0d", $time,
                     (V_END - V_START) * H_TOTAL, vrun);
            f_frame = 1'b1;
        end
    a_frame_per: assert property (@(posedge clk) disable iff (!rst_n)
        pix_cen && lvbl && !lvbl_q && v_seen |-> vper == V_TOTAL * H_TOTAL)
        else begin
            $display("FAIL %0t lvbl period exp %0d got %0d", $time, V_TOTAL * H_TOTAL, vper);
            f_fper = 1'b1;
        end
    a_vs_len: assert property (@(posedge clk) disable iff (!rst_n)
        pix_cen && lvbl && !lvbl_q && v_seen |-> vsrun == VS_LEN * H_TOTAL)
        else begin
            $display("FAIL %0t vs strobes per frame exp %0d got %0d", $time,
                     VS_LEN * H_TOTAL, vsrun);
            f_vs = 1'b1;
        end
    a_color: assert property (@(posedge clk) disable iff (!rst_n)
        pix_cen && lhbl && lvbl |-> {red, green, blue} == exp_rgb)
        else begin
            $display("FAIL %0t red/green/blue exp %h got %h", $time, exp_rgb,
                     {red, green, blue});
            f_color = 1'b1;
        end
    a_blank: assert property (@(posedge clk) disable iff (!rst_n)
        pix_cen && !(lhbl && lvbl) |-> {red, green, blue} == 12'h000)
        else begin
            $display("FAIL %0t red/green/blue exp 000 got %h", $time, {red, green, blue});
            f_blank = 1'b1;
        end

endmodule

// File: sim/arcade_video_tb.sv
// ==============================
// Arcade video testbench
// Tile and palette fill, read back, live tile update
// ==============================

`timescale 1ns/1ps

module arcade_video_tb import video_pkg::*; ();

    `include "rom_model.svh"

    localparam longint WATCH_NS = (4 * H_TOTAL * V_TOTAL * 2 + 50_000) * 4;

    logic clk = 1'b0;
    logic rst_n, pix_cen, char_cs, rnw, prom_red_we, prom_green_we, prom_blue_we;
    logic [CHRAM_AW-1:0] cpu_addr;
    logic [7:0]          cpu_dout, chram_dout;
    logic [CHROM_AW-1:0] char_addr;
    logic [15:0]         char_data;
    logic [PAL_AW-1:0]   prog_addr;
    logic [COLOR_W-1:0]  prom_din, red, green, blue;
    logic                lhbl, lvbl, hs, vs, chk_fail;
    logic [31:0]         lfsr = 32'd95343;
    logic [7:0]          chram_copy [2048];

    always #2 clk = ~clk;
    always @(posedge clk) pix_cen <= ~pix_cen;  // Every second clock
    assign char_data = rom_word(char_addr);

    arcade_video u_dut (.*);
    video_checker u_chk (.fail(chk_fail), .*);

    always @(posedge clk) begin
        if (chk_fail) begin
            $display("TEST FAILED");
            $fatal(1);
        end
    end

    initial begin
        #(WATCH_NS);
        $display("Run timed out before the third frame ended");
        $display("TEST FAILED");
        $fatal(1);
    end

    task automatic take_bits(input int n, output logic [10:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[9:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;  // Galois step
        end
    endtask

    task automatic bus_write(input logic [10:0] a, input logic [7:0] d);
        chram_copy[a] = d;
        cpu_addr <= a;
        cpu_dout <= d;
        char_cs  <= 1'b1;
        rnw      <= 1'b0;
        @(posedge clk);
        char_cs  <= 1'b0;
    endtask

    task automatic bus_read_check(input logic [10:0] a);
        cpu_addr <= a;
        char_cs  <= 1'b1;
        rnw      <= 1'b1;
        @(posedge clk);
        char_cs  <= 1'b0;
        @(posedge clk);
        assert (chram_dout == chram_copy[a]) else begin
            $display("FAIL %0t chram_dout exp %h got %h", $time, chram_copy[a], chram_dout);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic prom_write(input int sel, input logic [5:0] a, input logic [3:0] d);
        prog_addr     <= a;
        prom_din      <= d;
        prom_red_we   <= sel == 0;
        prom_green_we <= sel == 1;
        prom_blue_we  <= sel == 2;
        @(posedge clk);
        {prom_red_we, prom_green_we, prom_blue_we} <= 3'b000;
    endtask

    task automatic next_lvbl_rise();
        while (lvbl) @(posedge clk);
        while (!lvbl) @(posedge clk);
    endtask

    initial begin
        logic [10:0] a;
        logic [10:0] d;
        {rst_n, pix_cen, char_cs, rnw, prom_red_we, prom_green_we, prom_blue_we} = '0;
        cpu_addr  = '0;
        cpu_dout  = '0;
        prog_addr = '0;
        prom_din  = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        for (int i = 0; i < 2048; i++) begin  // Codes then attributes
            take_bits(8, d);
            bus_write(11'(i), d[7:0]);
        end
        for (int s = 0; s < 3; s++) begin
            for (int i = 0; i < 64; i++) begin
                take_bits(4, d);
                prom_write(s, 6'(i), d[3:0]);
            end
        end
        for (int i = 0; i < 8; i++) begin
            take_bits(10, a);
            a[10] = i[0];                     // Alternate code and attribute banks
            take_bits(8, d);
            bus_write(a, d[7:0]);
            bus_read_check(a);
        end
        next_lvbl_rise();
        next_lvbl_rise();                     // Second frame
        repeat (112) begin
            while (lhbl) @(posedge clk);
            while (!lhbl) @(posedge clk);
        end
        take_bits(8, d);
        bus_write(11'd69, d[7:0]);            // Tile at row 2 and column 5 is already drawn
        take_bits(8, d);
        bus_write(11'd1093, d[7:0]);
        next_lvbl_rise();
        while (lvbl) @(posedge clk);          // End of the third frame
        if (chk_fail) begin
            $display("TEST FAILED");
            $fatal(1);
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

// File: list.f
+incdir+sim
logic/video_pkg.sv
logic/video_if.sv
logic/video_timer.sv
logic/char_layer.sv
logic/palette_mix.sv
logic/arcade_video.sv
sim/video_checker.sv
sim/arcade_video_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= arcade_video_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST)) sim/rom_model.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q '^TEST OK$$'

clean:
	rm -rf $(OBJ_DIR)
